// File: hdl/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module decode_stage
  import legv8_pkg::*;
(
  input  wire                       CLOCK,
  input  wire                       arst_n,
  input  wire  [`LEGV8_XLEN-1:0]    ifid_pc,
  input  wire  [`LEGV8_INSN_W-1:0]  ifid_instr,
  input  wire  [`LEGV8_XLEN-1:0]    rd_data_a,
  input  wire  [`LEGV8_XLEN-1:0]    rd_data_b,
  pipe_ctrl_if.decode               ctrl,
  output logic [`LEGV8_REG_W-1:0]   rd_addr_a,
  output logic [`LEGV8_REG_W-1:0]   rd_addr_b,
  output ctrl_t                     ex_ctrl,
  output logic [`LEGV8_XLEN-1:0]    ex_opnd_a,
  output logic [`LEGV8_XLEN-1:0]    ex_opnd_b,
  output logic [`LEGV8_XLEN-1:0]    ex_imm
);

  opcode_e                 opcode;
  ctrl_t                   id_ctrl;
  logic [`LEGV8_REG_W-1:0] id_rm;
  logic [`LEGV8_XLEN-1:0]  id_imm;
  logic [`LEGV8_REG_W-1:0] ex_rd_q;
  logic [`LEGV8_REG_W-1:0] ex_rn_q;
  logic [`LEGV8_REG_W-1:0] ex_rm_q;

  always_comb begin
    case (ifid_instr[31:21])
      `LEGV8_OPC_ADD:  opcode = OPC_ADD;
      `LEGV8_OPC_SUB:  opcode = OPC_SUB;
      `LEGV8_OPC_AND:  opcode = OPC_AND;
      `LEGV8_OPC_ORR:  opcode = OPC_ORR;
      `LEGV8_OPC_LDUR: opcode = OPC_LDUR;
      `LEGV8_OPC_STUR: opcode = OPC_STUR;
      default:         opcode = OPC_NOP;
    endcase
  end

  always_comb begin
    id_ctrl = '0;
    case (opcode)
      OPC_ADD:  id_ctrl = '{alu_op: ALU_ADD, reg_write: 1'b1, default: 1'b0};
      OPC_SUB:  id_ctrl = '{alu_op: ALU_SUB, reg_write: 1'b1, default: 1'b0};
      OPC_AND:  id_ctrl = '{alu_op: ALU_AND, reg_write: 1'b1, default: 1'b0};
      OPC_ORR:  id_ctrl = '{alu_op: ALU_ORR, reg_write: 1'b1, default: 1'b0};
      OPC_LDUR: begin
        id_ctrl = '{alu_op: ALU_ADD, alu_src: 1'b1, mem_read: 1'b1,
                    reg_write: 1'b1, mem_to_reg: 1'b1, default: 1'b0};
      end
      OPC_STUR: begin
        id_ctrl = '{alu_op: ALU_ADD, alu_src: 1'b1, mem_write: 1'b1, default: 1'b0};
      end
      default:  id_ctrl = '0;
    endcase
  end

  // reg2loc picks Rt as the second source of STUR
  assign id_rm     = (opcode == OPC_STUR) ? ifid_instr[4:0] : ifid_instr[20:16];
  assign id_imm    = {{(`LEGV8_XLEN-9){ifid_instr[20]}}, ifid_instr[20:12]};
  assign rd_addr_a = ifid_instr[9:5];
  assign rd_addr_b = id_rm;

  // ID/EX control with a bubble on stall
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      ex_ctrl <= '0;
      ex_rd_q <= '0;
      ex_rn_q <= '0;
      ex_rm_q <= '0;
    end else begin
      ex_ctrl <= ctrl.stall ? ctrl_t'('0) : id_ctrl;
      ex_rd_q <= ifid_instr[4:0];
      ex_rn_q <= ifid_instr[9:5];
      ex_rm_q <= id_rm;
    end
  end

  always_ff @(posedge CLOCK) begin
    ex_opnd_a <= rd_data_a;
    ex_opnd_b <= rd_data_b;
    ex_imm    <= id_imm;
  end

  assign ctrl.id_rn       = ifid_instr[9:5];
  assign ctrl.id_rm       = id_rm;
  assign ctrl.ex_rd       = ex_rd_q;
  assign ctrl.ex_rn       = ex_rn_q;
  assign ctrl.ex_rm       = ex_rm_q;
  assign ctrl.ex_mem_read = ex_ctrl.mem_read;

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module execute_stage
  import legv8_pkg::*;
(
  input  wire                     CLOCK,
  input  wire                     arst_n,
  input  wire ctrl_t              ex_ctrl,
  input  wire  [`LEGV8_XLEN-1:0]  ex_opnd_a,
  input  wire  [`LEGV8_XLEN-1:0]  ex_opnd_b,
  input  wire  [`LEGV8_XLEN-1:0]  ex_imm,
  input  wire  [`LEGV8_XLEN-1:0]  wb_data,
  pipe_ctrl_if.execute            ctrl,
  output ctrl_t                   mem_ctrl,
  output logic [`LEGV8_XLEN-1:0]  mem_alu,
  output logic [`LEGV8_XLEN-1:0]  mem_store_data
);

  logic [`LEGV8_XLEN-1:0]  opnd_a;
  logic [`LEGV8_XLEN-1:0]  opnd_b;
  logic [`LEGV8_XLEN-1:0]  alu_b;
  logic [`LEGV8_XLEN-1:0]  alu_y;
  logic [`LEGV8_REG_W-1:0] mem_rd_q;

  function automatic logic [`LEGV8_XLEN-1:0] fwd_mux(
    input fwd_sel_e               sel,
    input logic [`LEGV8_XLEN-1:0] reg_val,
    input logic [`LEGV8_XLEN-1:0] mem_val,
    input logic [`LEGV8_XLEN-1:0] wb_val
  );
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign opnd_a = fwd_mux(ctrl.fwd_a, ex_opnd_a, mem_alu, wb_data);
  assign opnd_b = fwd_mux(ctrl.fwd_b, ex_opnd_b, mem_alu, wb_data);
  assign alu_b  = ex_ctrl.alu_src ? ex_imm : opnd_b;  // Offset for LDUR and STUR

  always_comb begin
    case (ex_ctrl.alu_op)
      ALU_AND: alu_y = opnd_a & alu_b;
      ALU_ORR: alu_y = opnd_a | alu_b;
      ALU_ADD: alu_y = opnd_a + alu_b;
      default: alu_y = opnd_a - alu_b;
    endcase
  end

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      mem_ctrl <= '0;
      mem_rd_q <= '0;
    end else begin
      mem_ctrl <= ex_ctrl;
      mem_rd_q <= ctrl.ex_rd;
    end
  end

  always_ff @(posedge CLOCK) begin
    mem_alu        <= alu_y;
    mem_store_data <= opnd_b;              // Forwarded Rt for stores
  end

  assign ctrl.mem_rd        = mem_rd_q;
  assign ctrl.mem_reg_write = mem_ctrl.reg_write;

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module fetch_stage (
  input  wire                       CLOCK,
  input  wire                       arst_n,
  input  wire  [`LEGV8_INSN_W-1:0]  instr,
  pipe_ctrl_if.fetch                ctrl,
  output logic [`LEGV8_XLEN-1:0]    pc,
  output logic [`LEGV8_XLEN-1:0]    ifid_pc,
  output logic [`LEGV8_INSN_W-1:0]  ifid_instr
);

  // PC and IF/ID both freeze on a load-use stall
  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      pc         <= '0;
      ifid_pc    <= '0;
      ifid_instr <= '0;                    // NOP word
    end else if (!ctrl.stall) begin
      pc         <= pc + `LEGV8_PC_STEP;
      ifid_pc    <= pc;
      ifid_instr <= instr;
    end
  end

endmodule

`default_nettype wire

// File: hdl/legv8_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module legv8_core
  import legv8_pkg::*;
(
  input  wire                        CLOCK,
  input  wire                        arst_n,
  input  wire  [`LEGV8_INSN_W-1:0]   instr,       // Instruction at pc
  input  wire  [`LEGV8_XLEN-1:0]     mem_rdata,
  output logic [`LEGV8_XLEN-1:0]     pc,
  output logic [`LEGV8_XLEN-1:0]     mem_addr,
  output logic [`LEGV8_XLEN-1:0]     mem_wdata,
  output logic                       mem_read,
  output logic                       mem_write,
  output logic                       wb_valid,
  output logic [`LEGV8_REG_W-1:0]    wb_reg,
  output logic [`LEGV8_XLEN-1:0]     wb_data
);

  logic [`LEGV8_XLEN-1:0]   ifid_pc;
  logic [`LEGV8_INSN_W-1:0] ifid_instr;
  logic [`LEGV8_REG_W-1:0]  rd_addr_a;
  logic [`LEGV8_REG_W-1:0]  rd_addr_b;
  logic [`LEGV8_XLEN-1:0]   rd_data_a;
  logic [`LEGV8_XLEN-1:0]   rd_data_b;
  ctrl_t                    ex_ctrl;
  logic [`LEGV8_XLEN-1:0]   ex_opnd_a;
  logic [`LEGV8_XLEN-1:0]   ex_opnd_b;
  logic [`LEGV8_XLEN-1:0]   ex_imm;
  ctrl_t                    mem_ctrl;
  logic [`LEGV8_XLEN-1:0]   mem_alu;
  logic [`LEGV8_XLEN-1:0]   mem_store_data;

  pipe_ctrl_if u_pipe_ctrl ();

  fetch_stage u_fetch (
    .CLOCK(CLOCK), .arst_n(arst_n), .instr(instr), .ctrl(u_pipe_ctrl.fetch),
    .pc(pc), .ifid_pc(ifid_pc), .ifid_instr(ifid_instr)
  );

  decode_stage u_decode (
    .CLOCK(CLOCK), .arst_n(arst_n), .ifid_pc(ifid_pc), .ifid_instr(ifid_instr),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .ctrl(u_pipe_ctrl.decode),
    .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b), .ex_ctrl(ex_ctrl),
    .ex_opnd_a(ex_opnd_a), .ex_opnd_b(ex_opnd_b), .ex_imm(ex_imm)
  );

  reg_file u_reg_file (
    .CLOCK(CLOCK), .arst_n(arst_n), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .wb_valid(wb_valid),
    .wb_reg(wb_reg), .wb_data(wb_data)
  );

  execute_stage u_execute (
    .CLOCK(CLOCK), .arst_n(arst_n), .ex_ctrl(ex_ctrl), .ex_opnd_a(ex_opnd_a),
    .ex_opnd_b(ex_opnd_b), .ex_imm(ex_imm), .wb_data(wb_data),
    .ctrl(u_pipe_ctrl.execute), .mem_ctrl(mem_ctrl), .mem_alu(mem_alu),
    .mem_store_data(mem_store_data)
  );

  memory_writeback u_mem_wb (
    .CLOCK(CLOCK), .arst_n(arst_n), .mem_ctrl(mem_ctrl), .mem_alu(mem_alu),
    .mem_store_data(mem_store_data), .mem_rdata(mem_rdata),
    .ctrl(u_pipe_ctrl.writeback), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_read(mem_read), .mem_write(mem_write), .wb_valid(wb_valid),
    .wb_reg(wb_reg), .wb_data(wb_data)
  );

  pipeline_control u_pipe_control (.ctrl(u_pipe_ctrl.control));

endmodule

`default_nettype wire

// File: hdl/legv8_pkg.sv
`default_nettype none

package legv8_pkg;

  // Decoded instruction class
  typedef enum logic [2:0] {
    OPC_ADD,
    OPC_SUB,
    OPC_AND,
    OPC_ORR,
    OPC_LDUR,
    OPC_STUR,
    OPC_NOP
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_AND = 2'd0,
    ALU_ORR = 2'd1,
    ALU_ADD = 2'd2,
    ALU_SUB = 2'd3
  } alu_op_e;

  // Operand source in EX
  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_WB   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_sel_e;

  // All-zero word is a bubble
  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src;     // Immediate as ALU input B
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;  // Load data to Rd
  } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/memory_writeback.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module memory_writeback
  import legv8_pkg::*;
(
  input  wire                      CLOCK,
  input  wire                      arst_n,
  input  wire ctrl_t               mem_ctrl,
  input  wire  [`LEGV8_XLEN-1:0]   mem_alu,
  input  wire  [`LEGV8_XLEN-1:0]   mem_store_data,
  input  wire  [`LEGV8_XLEN-1:0]   mem_rdata,
  pipe_ctrl_if.writeback           ctrl,
  output logic [`LEGV8_XLEN-1:0]   mem_addr,
  output logic [`LEGV8_XLEN-1:0]   mem_wdata,
  output logic                     mem_read,
  output logic                     mem_write,
  output logic                     wb_valid,
  output logic [`LEGV8_REG_W-1:0]  wb_reg,
  output logic [`LEGV8_XLEN-1:0]   wb_data
);

  logic                    wb_reg_write_q;
  logic                    wb_mem_to_reg_q;
  logic [`LEGV8_REG_W-1:0] wb_rd_q;
  logic [`LEGV8_XLEN-1:0]  wb_alu_q;
  logic [`LEGV8_XLEN-1:0]  wb_load_q;

  assign mem_addr  = mem_alu;              // Base plus offset
  assign mem_wdata = mem_store_data;
  assign mem_read  = mem_ctrl.mem_read;
  assign mem_write = mem_ctrl.mem_write;

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      wb_reg_write_q  <= 1'b0;
      wb_mem_to_reg_q <= 1'b0;
      wb_rd_q         <= '0;
    end else begin
      wb_reg_write_q  <= mem_ctrl.reg_write;
      wb_mem_to_reg_q <= mem_ctrl.mem_to_reg;
      wb_rd_q         <= ctrl.mem_rd;
    end
  end

  always_ff @(posedge CLOCK) begin
    wb_alu_q  <= mem_alu;
    wb_load_q <= mem_rdata;
  end

  // Writes to x31 are discarded here
  assign wb_valid          = wb_reg_write_q && (wb_rd_q != `LEGV8_ZERO_REG);
  assign wb_reg            = wb_rd_q;
  assign wb_data           = wb_mem_to_reg_q ? wb_load_q : wb_alu_q;
  assign ctrl.wb_rd        = wb_rd_q;
  assign ctrl.wb_reg_write = wb_valid;

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

interface pipe_ctrl_if
  import legv8_pkg::*;
();

  logic [`LEGV8_REG_W-1:0] id_rn;         // ID sources after reg2loc
  logic [`LEGV8_REG_W-1:0] id_rm;
  logic [`LEGV8_REG_W-1:0] ex_rd;         // ID/EX fields
  logic [`LEGV8_REG_W-1:0] ex_rn;
  logic [`LEGV8_REG_W-1:0] ex_rm;
  logic                    ex_mem_read;
  logic [`LEGV8_REG_W-1:0] mem_rd;        // EX/MEM destination
  logic                    mem_reg_write;
  logic [`LEGV8_REG_W-1:0] wb_rd;         // MEM/WB destination
  logic                    wb_reg_write;
  logic                    stall;
  fwd_sel_e                fwd_a;
  fwd_sel_e                fwd_b;

  modport control (
    input  id_rn, id_rm, ex_rd, ex_rn, ex_rm, ex_mem_read,
    input  mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    output stall, fwd_a, fwd_b
  );
  modport fetch (input stall);
  modport decode (output id_rn, id_rm, ex_rd, ex_rn, ex_rm, ex_mem_read, input stall);
  modport execute (input ex_rd, fwd_a, fwd_b, output mem_rd, mem_reg_write);
  modport writeback (input mem_rd, output wb_rd, wb_reg_write);

endinterface

`default_nettype wire

// File: hdl/pipeline_control.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module pipeline_control
  import legv8_pkg::*;
(
  pipe_ctrl_if.control ctrl
);

  // MEM result is newer than WB, so it is checked first
  function automatic fwd_sel_e pick_source(
    input logic [`LEGV8_REG_W-1:0] src,
    input logic                    mem_wr,
    input logic [`LEGV8_REG_W-1:0] mem_rd,
    input logic                    wb_wr,
    input logic [`LEGV8_REG_W-1:0] wb_rd
  );
    if (mem_wr && (mem_rd != `LEGV8_ZERO_REG) && (mem_rd == src)) return FWD_MEM;
    if (wb_wr && (wb_rd != `LEGV8_ZERO_REG) && (wb_rd == src)) return FWD_WB;
    return FWD_NONE;
  endfunction

  // Load in EX feeding the instruction in ID
  assign ctrl.stall = ctrl.ex_mem_read && (ctrl.ex_rd != `LEGV8_ZERO_REG) &&
                      ((ctrl.ex_rd == ctrl.id_rn) || (ctrl.ex_rd == ctrl.id_rm));

  assign ctrl.fwd_a = pick_source(ctrl.ex_rn, ctrl.mem_reg_write, ctrl.mem_rd,
                                  ctrl.wb_reg_write, ctrl.wb_rd);
  assign ctrl.fwd_b = pick_source(ctrl.ex_rm, ctrl.mem_reg_write, ctrl.mem_rd,
                                  ctrl.wb_reg_write, ctrl.wb_rd);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module reg_file (
  input  wire                      CLOCK,
  input  wire                      arst_n,
  input  wire  [`LEGV8_REG_W-1:0]  rd_addr_a,
  input  wire  [`LEGV8_REG_W-1:0]  rd_addr_b,
  output logic [`LEGV8_XLEN-1:0]   rd_data_a,
  output logic [`LEGV8_XLEN-1:0]   rd_data_b,
  input  wire                      wb_valid,
  input  wire  [`LEGV8_REG_W-1:0]  wb_reg,
  input  wire  [`LEGV8_XLEN-1:0]   wb_data
);

  logic [`LEGV8_XLEN-1:0] regs [0:(1<<`LEGV8_REG_W)-1];

  // Write-first read with x31 forced to zero
  function automatic logic [`LEGV8_XLEN-1:0] read_port(
    input logic [`LEGV8_REG_W-1:0] addr,
    input logic [`LEGV8_XLEN-1:0]  stored
  );
    if (addr == `LEGV8_ZERO_REG) return '0;
    if (wb_valid && (wb_reg == addr)) return wb_data;
    return stored;
  endfunction

  always_ff @(posedge CLOCK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < (1 << `LEGV8_REG_W); i++) begin
        regs[i[4:0]] <= {{(`LEGV8_XLEN-32){1'b0}}, i[31:0]};  // Register i holds i
      end
    end else if (wb_valid) begin
      regs[wb_reg] <= wb_data;
    end
  end

  always_comb begin
    rd_data_a = read_port(rd_addr_a, regs[rd_addr_a]);
    rd_data_b = read_port(rd_addr_b, regs[rd_addr_b]);
  end

endmodule

`default_nettype wire

// File: include/legv8_defines.svh
`ifndef LEGV8_DEFINES_SVH
`define LEGV8_DEFINES_SVH

// Datapath widths
`define LEGV8_XLEN      64
`define LEGV8_INSN_W    32
`define LEGV8_REG_W     5
`define LEGV8_OPC_W     11

`define LEGV8_ZERO_REG  31   // x31 reads as zero
`define LEGV8_PC_STEP   4    // One instruction per fetch

// Primary opcode field, instr[31:21]
`define LEGV8_OPC_ADD   11'b10001011000
`define LEGV8_OPC_SUB   11'b11001011000
`define LEGV8_OPC_AND   11'b10001010000
`define LEGV8_OPC_ORR   11'b10101010000
`define LEGV8_OPC_LDUR  11'b11111000010
`define LEGV8_OPC_STUR  11'b11111000000

`endif

// File: legv8_core.f
+incdir+include
hdl/legv8_pkg.sv
hdl/pipe_ctrl_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/pipeline_control.sv
hdl/legv8_core.sv
sim/legv8_checker.sv
sim/tb_legv8_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --top-module tb_legv8_core -o tb_legv8_core -f legv8_core.f
./obj_dir/tb_legv8_core > sim.log 2>&1
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi
echo "Simulation finished without failures"

// File: sim/legv8_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module legv8_checker (
  input  wire                       CLOCK,
  input  wire                       arst_n,
  input  logic [`LEGV8_INSN_W-1:0]  prog [0:255],
  input  wire  [`LEGV8_XLEN-1:0]    pc,
  input  wire  [`LEGV8_XLEN-1:0]    mem_addr,
  input  wire  [`LEGV8_XLEN-1:0]    mem_wdata,
  input  wire                       mem_read,
  input  wire                       mem_write,
  input  wire                       wb_valid,
  input  wire  [`LEGV8_REG_W-1:0]   wb_reg,
  input  wire  [`LEGV8_XLEN-1:0]    wb_data,
  input  wire                       run_done,     // No more events expected
  output int                        error_count,
  output int                        wb_count,
  output int                        store_count,
  output logic                      report_done
);

  logic [`LEGV8_REG_W-1:0] exp_wb_reg [$];
  logic [`LEGV8_XLEN-1:0]  exp_wb_data [$];
  logic [`LEGV8_XLEN-1:0]  exp_st_addr [$];
  logic [`LEGV8_XLEN-1:0]  exp_st_data [$];
  logic [`LEGV8_XLEN-1:0]  exp_ld_addr [$];
  logic [`LEGV8_REG_W-1:0] e_reg;
  logic [`LEGV8_XLEN-1:0]  e_val;
  logic [`LEGV8_XLEN-1:0]  e_addr;
  logic                    model_built = 1'b0;
  logic                    reported = 1'b0;
  int                      errors = 0;
  int                      n_wb = 0;
  int                      n_st = 0;

  assign error_count = errors;
  assign wb_count    = n_wb;
  assign store_count = n_st;
  assign report_done = reported;

  // In-order ISA model of the whole program memory
  function automatic void build_expected();
    logic [`LEGV8_XLEN-1:0]   regs [0:31];
    logic [`LEGV8_XLEN-1:0]   dmem [0:127];
    logic [`LEGV8_INSN_W-1:0] insn;
    logic [`LEGV8_XLEN-1:0]   a;
    logic [`LEGV8_XLEN-1:0]   b;
    logic [`LEGV8_XLEN-1:0]   addr;
    logic [`LEGV8_XLEN-1:0]   res;
    logic                     writes;
    for (int i = 0; i < 32; i++) begin
      regs[i[4:0]] = (i == `LEGV8_ZERO_REG) ? 64'd0 : 64'(i);   // Register i starts at i
    end
    for (int i = 0; i < 128; i++) begin
      dmem[i[6:0]] = 64'(i) * 64'd5;
    end
    for (int k = 0; k < 256; k++) begin
      insn   = prog[k[7:0]];
      a      = regs[insn[9:5]];
      b      = regs[insn[20:16]];
      addr   = a + {{(`LEGV8_XLEN-9){insn[20]}}, insn[20:12]};
      res    = '0;
      writes = 1'b1;
      case (insn[31:21])
        `LEGV8_OPC_ADD:  res = a + b;
        `LEGV8_OPC_SUB:  res = a - b;
        `LEGV8_OPC_AND:  res = a & b;
        `LEGV8_OPC_ORR:  res = a | b;
        `LEGV8_OPC_LDUR: begin
          res = dmem[addr[9:3]];
          exp_ld_addr.push_back(addr);
        end
        `LEGV8_OPC_STUR: begin
          writes = 1'b0;
          dmem[addr[9:3]] = regs[insn[4:0]];    // Rt is the store source
          exp_st_addr.push_back(addr);
          exp_st_data.push_back(regs[insn[4:0]]);
        end
        default: writes = 1'b0;                 // Unknown words do nothing
      endcase
      if (writes && (insn[4:0] != `LEGV8_ZERO_REG)) begin
        regs[insn[4:0]] = res;
        exp_wb_reg.push_back(insn[4:0]);
        exp_wb_data.push_back(res);
      end
    end
  endfunction

  always @(negedge CLOCK) begin
    if (!arst_n) begin
      if (mem_read || mem_write || wb_valid || (pc != '0)) begin
        $display("FAIL at %0t: DUT not idle in reset, pc=%h rd=%b wr=%b wb=%b",
                 $time, pc, mem_read, mem_write, wb_valid);
        errors = errors + 1;
      end
    end else begin
      if (!model_built) begin
        build_expected();
        model_built = 1'b1;
      end
      if (wb_valid) begin
        if (exp_wb_reg.size() == 0) begin
          $display("Extra write-back to x%0d at time %0t, none was expected", wb_reg, $time);
          errors = errors + 1;
        end else begin
          e_reg = exp_wb_reg.pop_front();
          e_val = exp_wb_data.pop_front();
          if ((wb_reg !== e_reg) || (wb_data !== e_val)) begin
            $display("FAIL at %0t: write-back %0d gave x%0d=%h, expected x%0d=%h",
                     $time, n_wb, wb_reg, wb_data, e_reg, e_val);
            errors = errors + 1;
          end
          n_wb = n_wb + 1;
        end
      end
      if (mem_read) begin
        if (exp_ld_addr.size() == 0) begin
          $display("Extra load from address %h at time %0t, none was expected", mem_addr, $time);
          errors = errors + 1;
        end else begin
          e_addr = exp_ld_addr.pop_front();
          if (mem_addr !== e_addr) begin
            $display("FAIL at %0t: load read address %h, expected %h",
                     $time, mem_addr, e_addr);
            errors = errors + 1;
          end
        end
      end
      if (mem_write) begin
        if (exp_st_addr.size() == 0) begin
          $display("Extra store to address %h at time %0t, none was expected", mem_addr, $time);
          errors = errors + 1;
        end else begin
          e_addr = exp_st_addr.pop_front();
          e_val  = exp_st_data.pop_front();
          if ((mem_addr !== e_addr) || (mem_wdata !== e_val)) begin
            $display("FAIL at %0t: store %0d gave [%h]=%h, expected [%h]=%h",
                     $time, n_st, mem_addr, mem_wdata, e_addr, e_val);
            errors = errors + 1;
          end
          n_st = n_st + 1;
        end
      end
      if (run_done && !reported) begin
        if (exp_wb_reg.size() != 0) begin
          $display("%0d expected write-backs never appeared", exp_wb_reg.size());
          errors = errors + 1;
        end
        if (exp_ld_addr.size() != 0) begin
          $display("%0d expected loads never appeared", exp_ld_addr.size());
          errors = errors + 1;
        end
        if (exp_st_addr.size() != 0) begin
          $display("%0d expected stores never appeared", exp_st_addr.size());
          errors = errors + 1;
        end
        reported = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_legv8_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "legv8_defines.svh"

module tb_legv8_core;

  localparam int PROG_DEPTH = 256;              // Instruction memory words
  localparam int RAND_LEN   = 200;
  localparam int TIMEOUT    = 2000;             // Cycles allowed per wait loop
  localparam int END_PC     = PROG_DEPTH * 4 + 36;

  logic                      CLOCK;
  logic                      arst_n;
  logic [`LEGV8_INSN_W-1:0]  instr;
  logic [`LEGV8_XLEN-1:0]    mem_rdata;
  logic [`LEGV8_XLEN-1:0]    pc;
  logic [`LEGV8_XLEN-1:0]    mem_addr;
  logic [`LEGV8_XLEN-1:0]    mem_wdata;
  logic                      mem_read;
  logic                      mem_write;
  logic                      wb_valid;
  logic [`LEGV8_REG_W-1:0]   wb_reg;
  logic [`LEGV8_XLEN-1:0]    wb_data;
  logic [`LEGV8_INSN_W-1:0]  prog [0:PROG_DEPTH-1];
  logic [`LEGV8_XLEN-1:0]    dmem [0:127];
  logic [15:0]               lfsr;
  int                        prog_len;
  logic                      run_done;
  logic                      report_done;
  int                        error_count;
  int                        wb_count;
  int                        store_count;
  int                        run_errors;

  legv8_core u_legv8_core (
    .CLOCK(CLOCK), .arst_n(arst_n), .instr(instr), .mem_rdata(mem_rdata), .pc(pc),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_read(mem_read),
    .mem_write(mem_write), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  legv8_checker u_checker (
    .CLOCK(CLOCK), .arst_n(arst_n), .prog(prog), .pc(pc), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata), .mem_read(mem_read), .mem_write(mem_write),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .run_done(run_done),
    .error_count(error_count), .wb_count(wb_count), .store_count(store_count),
    .report_done(report_done)
  );

  // NOP word past the end of the program
  assign instr     = (pc[63:10] == '0) ? prog[pc[9:2]] : '0;
  assign mem_rdata = mem_read ? dmem[mem_addr[9:3]] : '0;

  always @(posedge CLOCK) begin
    if (!arst_n) begin
      for (int i = 0; i < 128; i++) begin
        dmem[i[6:0]] <= 64'(i) * 64'd5;     // Word i starts at i*5
      end
    end else if (mem_write) begin
      dmem[mem_addr[9:3]] <= mem_wdata;
    end
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] r_word(
    input logic [10:0] opc,
    input logic [4:0]  rd,
    input logic [4:0]  rn,
    input logic [4:0]  rm
  );
    return {opc, rm, 6'd0, rn, rd};
  endfunction

  function automatic logic [31:0] d_word(
    input logic [10:0] opc,
    input logic [4:0]  rt,
    input logic [4:0]  rn,
    input logic [8:0]  off
  );
    return {opc, off, 2'b00, rn, rt};
  endfunction

  function automatic void put_word(input logic [31:0] word);
    prog[prog_len[7:0]] = word;
    prog_len = prog_len + 1;
  endfunction

  function automatic void build_program();
    logic [2:0] kind;
    logic [4:0] rd;
    logic [4:0] rn;
    logic [4:0] rm;
    logic [8:0] off;
    prog_len = 0;
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog[i[7:0]] = '0;
    end
    put_word(r_word(`LEGV8_OPC_ADD, 5'd1, 5'd2, 5'd3));     // Independent R-type
    put_word(r_word(`LEGV8_OPC_SUB, 5'd4, 5'd10, 5'd6));
    put_word(r_word(`LEGV8_OPC_AND, 5'd5, 5'd7, 5'd12));
    put_word(r_word(`LEGV8_OPC_ORR, 5'd8, 5'd9, 5'd20));
    put_word(r_word(`LEGV8_OPC_ADD, 5'd13, 5'd2, 5'd3));
    put_word(r_word(`LEGV8_OPC_ADD, 5'd14, 5'd13, 5'd13));  // Distance 1
    put_word(r_word(`LEGV8_OPC_ORR, 5'd15, 5'd13, 5'd16));  // Distance 2
    put_word(r_word(`LEGV8_OPC_SUB, 5'd16, 5'd17, 5'd13));  // Distance 3 on Rm
    put_word(r_word(`LEGV8_OPC_AND, 5'd17, 5'd16, 5'd14));
    put_word(d_word(`LEGV8_OPC_LDUR, 5'd18, 5'd0, 9'd16));
    put_word(r_word(`LEGV8_OPC_ADD, 5'd19, 5'd18, 5'd18));  // Load-use stall
    put_word(d_word(`LEGV8_OPC_LDUR, 5'd20, 5'd0, 9'd24));
    put_word(d_word(`LEGV8_OPC_STUR, 5'd20, 5'd0, 9'd32));  // Stall on store data
    put_word(d_word(`LEGV8_OPC_LDUR, 5'd21, 5'd0, 9'd40));
    put_word(d_word(`LEGV8_OPC_STUR, 5'd9, 5'd21, 9'd0));   // Stall on base
    put_word(r_word(`LEGV8_OPC_ADD, 5'd31, 5'd1, 5'd2));    // Dropped write
    put_word(r_word(`LEGV8_OPC_ORR, 5'd22, 5'd31, 5'd31));
    put_word(d_word(`LEGV8_OPC_STUR, 5'd31, 5'd0, 9'd48));
    put_word(d_word(`LEGV8_OPC_STUR, 5'd14, 5'd8, 9'h1F8)); // Offset -8
    put_word(d_word(`LEGV8_OPC_LDUR, 5'd23, 5'd8, 9'h1F8));
    put_word(d_word(`LEGV8_OPC_LDUR, 5'd31, 5'd0, 9'd8));
    put_word(r_word(`LEGV8_OPC_ADD, 5'd24, 5'd31, 5'd5));
    put_word(32'd0);
    put_word(r_word(11'h7FF, 5'd25, 5'd1, 5'd2));           // Unknown opcode
    for (int k = 0; k < RAND_LEN; k++) begin
      kind = 3'(take_bits(3));
      rd   = 5'(take_bits(5));
      rn   = 5'(take_bits(5));
      rm   = 5'(take_bits(5));
      off  = 9'(take_bits(9));
      case (kind)
        3'd0, 3'd1: put_word(r_word(`LEGV8_OPC_ADD, rd, rn, rm));
        3'd2:       put_word(r_word(`LEGV8_OPC_SUB, rd, rn, rm));
        3'd3:       put_word(r_word(`LEGV8_OPC_AND, rd, rn, rm));
        3'd4:       put_word(r_word(`LEGV8_OPC_ORR, rd, rn, rm));
        3'd5:       put_word(d_word(`LEGV8_OPC_LDUR, rd, rn, off));
        3'd6:       put_word(d_word(`LEGV8_OPC_STUR, rd, rn, off));
        default:    put_word(take_bits(32));
      endcase
    end
  endfunction

  initial begin
    CLOCK = 1'b0;
    forever #10 CLOCK = ~CLOCK;
  end

  initial begin
    int cycles;
    arst_n     <= 1'b0;
    run_done   <= 1'b0;
    run_errors = 0;
    lfsr       = 16'd9451;
    build_program();
    repeat (10) @(posedge CLOCK);
    arst_n <= 1'b1;
    cycles = 0;
    while ((pc < 64'(END_PC)) && (cycles < TIMEOUT)) begin
      @(posedge CLOCK);
      cycles = cycles + 1;
    end
    if (cycles >= TIMEOUT) begin
      $display("Timeout: the program counter never passed the end of the program");
      run_errors = run_errors + 1;
    end
    run_done <= 1'b1;
    cycles = 0;
    while (!report_done && (cycles < TIMEOUT)) begin
      @(posedge CLOCK);
      cycles = cycles + 1;
    end
    if (!report_done) begin
      $display("Timeout: the checker never gave its final report");
      run_errors = run_errors + 1;
    end
    $display("Write-backs checked: %0d, stores checked: %0d, errors: %0d",
             wb_count, store_count, error_count + run_errors);
    if ((error_count == 0) && (run_errors == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
